/* compile.f */
hw/axil_pkg.sv
hw/mem_map_pkg.sv
hw/axil_req_decode.sv
hw/axil_sram_bank.sv
hw/axil_resp_merge.sv
hw/axil_sram_top.sv
dv/axil_sram_chk.sv
dv/axil_sram_tb.sv

/* Makefile */
TOP := axil_sram_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a status"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

/* dv/axil_sram_tb.sv */
module axil_sram_tb;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_FULL     = 16;
    localparam int NUM_PART     = 8;
    localparam int NUM_ORDER    = 12;
    // One write and one read per item
    localparam int NUM_SEQ      = 2 * (NUM_FULL + NUM_PART + NUM_ORDER);
    localparam int MAX_CYCLES   = NUM_SEQ * 20 + RESET_CYCLES;
    localparam int WAIT_LIMIT   = 16;

    logic              CLK;
    logic              rstn;
    axil_pkg::ar_req_t ar;
    axil_pkg::aw_req_t aw;
    axil_pkg::w_req_t  w;
    logic              rready;
    logic              bready;
    logic              arready;
    logic              awready;
    logic              wready;
    axil_pkg::r_rsp_t  r;
    axil_pkg::b_rsp_t  b;

    int                tb_errors = 0;
    int                cycles = 0;
    axil_pkg::addr_t   used_addr [$];

    axil_sram_top dut_i (
        .CLK     (CLK),
        .rstn    (rstn),
        .ar      (ar),
        .aw      (aw),
        .w       (w),
        .rready  (rready),
        .bready  (bready),
        .arready (arready),
        .awready (awready),
        .wready  (wready),
        .r       (r),
        .b       (b)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // Readies sampled at the falling edge, valids dropped after the handshake edge
    task automatic issue_requests();
        int   n;
        logic ar_go;
        logic aw_go;
        logic w_go;
        n = 0;
        while ((ar.arvalid || aw.awvalid || w.wvalid) && n < WAIT_LIMIT) begin
            @(negedge CLK);
            ar_go = ar.arvalid && arready;
            aw_go = aw.awvalid && awready;
            w_go  = w.wvalid && wready;
            @(posedge CLK);
            #1;
            if (ar_go) ar.arvalid = 1'b0;
            if (aw_go) aw.awvalid = 1'b0;
            if (w_go) w.wvalid = 1'b0;
            n++;
        end
        if (ar.arvalid || aw.awvalid || w.wvalid) begin
            $display("request not accepted within %0d cycles at %0t", WAIT_LIMIT, $time);
            tb_errors++;
            ar.arvalid = 1'b0;
            aw.awvalid = 1'b0;
            w.wvalid   = 1'b0;
        end
    endtask

    // Back-pressure for a random number of cycles, then take the response
    task automatic take_response(input bit is_read);
        int n;
        int stall;
        n     = 0;
        stall = $urandom_range(4, 0);
        @(negedge CLK);
        while (!(is_read ? r.rvalid : b.bvalid) && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (!(is_read ? r.rvalid : b.bvalid)) begin
            $display("no %s response within %0d cycles at %0t",
                     is_read ? "read" : "write", WAIT_LIMIT, $time);
            tb_errors++;
        end else begin
            repeat (stall + 1) @(posedge CLK);
            #1;
            rready = is_read;
            bready = !is_read;
            @(posedge CLK);
            #1;
            rready = 1'b0;
            bready = 1'b0;
        end
    endtask

    // order 0 address first, 1 data first, 2 both together
    task automatic write_word(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                              input axil_pkg::strb_t strb, input int order);
        aw.awaddr = addr;
        w.wdata   = data;
        w.wstrb   = strb;
        case (order)
            0: begin
                aw.awvalid = 1'b1;
                issue_requests();
                w.wvalid = 1'b1;
            end
            1: begin
                w.wvalid = 1'b1;
                repeat ($urandom_range(3, 1)) @(posedge CLK);
                #1;
                aw.awvalid = 1'b1;
            end
            default: begin
                aw.awvalid = 1'b1;
                w.wvalid   = 1'b1;
            end
        endcase
        issue_requests();
        take_response(1'b0);
    endtask

    task automatic read_word(input axil_pkg::addr_t addr);
        ar.araddr  = addr;
        ar.arvalid = 1'b1;
        issue_requests();
        take_response(1'b1);
    endtask

    // Bank field forced, upper bits random so aliasing gets exercised
    function automatic axil_pkg::addr_t pick_addr(input int bank);
        axil_pkg::addr_t a;
        a      = $urandom;
        a[3:2] = bank[1:0];
        return a;
    endfunction

    initial begin
        axil_pkg::addr_t addr;
        rstn   = 1'b1;
        ar     = '0;
        aw     = '0;
        w      = '0;
        rready = 1'b0;
        bready = 1'b0;
        void'($urandom(32'h3694));
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        rstn = 1'b0;
        repeat (2) @(posedge CLK);
        #1;

        // Full words across all banks, read straight back
        for (int i = 0; i < NUM_FULL; i++) begin
            addr = pick_addr(i % mem_map_pkg::NUM_BANKS);
            used_addr.push_back(addr);
            write_word(addr, $urandom, 4'hf, 2);
            read_word(addr);
        end

        // Partial strobes on words that already hold known data
        for (int i = 0; i < NUM_PART; i++) begin
            addr = used_addr[$urandom_range(NUM_FULL - 1, 0)];
            write_word(addr, $urandom, axil_pkg::strb_t'($urandom_range(14, 1)),
                       $urandom_range(2, 0));
            read_word(addr);
        end

        // Every channel order in turn
        for (int i = 0; i < NUM_ORDER; i++) begin
            addr = used_addr[$urandom_range(NUM_FULL - 1, 0)];
            write_word(addr, $urandom, axil_pkg::strb_t'($urandom_range(15, 1)), i % 3);
            read_word(addr);
        end

        repeat (4) @(posedge CLK);
        $display("errors: assertions %0d, testbench %0d", dut_i.chk_i.errors, tb_errors);
        if (dut_i.chk_i.errors == 0 && tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", MAX_CYCLES);
        $display("errors: assertions %0d, testbench %0d", dut_i.chk_i.errors, tb_errors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* dv/axil_sram_chk.sv */
module axil_sram_chk (
    input logic              CLK,
    input logic              rstn,
    input axil_pkg::ar_req_t ar,
    input axil_pkg::aw_req_t aw,
    input axil_pkg::w_req_t  w,
    input logic              rready,
    input logic              bready,
    input logic              arready,
    input logic              awready,
    input logic              wready,
    input axil_pkg::r_rsp_t  r,
    input axil_pkg::b_rsp_t  b
);

    // Word key is bank field plus word field, upper bits alias
    localparam int KEY_W = mem_map_pkg::BANK_IDX_W + mem_map_pkg::WORD_IDX_W;

    int               errors = 0;
    axil_pkg::data_t  shadow [1 << KEY_W];
    axil_pkg::data_t  exp_rdata;
    axil_pkg::addr_t  awaddr_q;
    axil_pkg::data_t  wdata_q;
    axil_pkg::strb_t  wstrb_q;
    axil_pkg::addr_t  wr_addr;
    axil_pkg::data_t  wr_data;
    axil_pkg::strb_t  wr_strb;
    logic [KEY_W-1:0] wr_key;
    logic [KEY_W-1:0] rd_key;
    logic             aw_seen;
    logic             w_seen;
    logic             rd_out;
    logic             wr_out;
    logic             ar_hs;
    logic             aw_hs;
    logic             w_hs;
    logic             r_hs;
    logic             b_hs;
    logic             wr_last;

    assign ar_hs = ar.arvalid && arready;
    assign aw_hs = aw.awvalid && awready;
    assign w_hs  = w.wvalid && wready;
    assign r_hs  = r.rvalid && rready;
    assign b_hs  = b.bvalid && bready;

    // Edge where the later of address and data is taken
    assign wr_last = (aw_hs || aw_seen) && (w_hs || w_seen) && (aw_hs || w_hs);
    assign wr_addr = aw_hs ? aw.awaddr : awaddr_q;
    assign wr_data = w_hs ? w.wdata : wdata_q;
    assign wr_strb = w_hs ? w.wstrb : wstrb_q;
    assign wr_key  = wr_addr[mem_map_pkg::BANK_LSB +: KEY_W];
    assign rd_key  = ar.araddr[mem_map_pkg::BANK_LSB +: KEY_W];

    always_ff @(posedge CLK) begin
        if (rstn) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            rd_out  <= 1'b0;
            wr_out  <= 1'b0;
        end else begin
            if (ar_hs) begin
                rd_out    <= 1'b1;
                exp_rdata <= shadow[rd_key];
            end else if (r_hs) begin
                rd_out <= 1'b0;
            end
            if (aw_hs) begin
                wr_out   <= 1'b1;
                awaddr_q <= aw.awaddr;
            end else if (b_hs) begin
                wr_out <= 1'b0;
            end
            if (w_hs) begin
                wdata_q <= w.wdata;
                wstrb_q <= w.wstrb;
            end
            if (wr_last) begin
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
                // Only strobed byte lanes change
                for (int i = 0; i < axil_pkg::STRB_W; i++) begin
                    if (wr_strb[i]) begin
                        shadow[wr_key][8*i +: 8] <= wr_data[8*i +: 8];
                    end
                end
            end else begin
                if (aw_hs) begin
                    aw_seen <= 1'b1;
                end
                if (w_hs) begin
                    w_seen <= 1'b1;
                end
            end
        end
    end

    // Outputs idle through reset and on the first edge after it
    a_reset_idle: assert property (@(posedge CLK)
        $past(rstn) |-> !arready && !awready && !wready && !r.rvalid && !b.bvalid)
        else begin
            errors++;
            $error("ready or valid output high right after reset");
        end

    // A register that changes on the second edge is first sampled high one edge later
    a_r_latency: assert property (@(posedge CLK) disable iff (rstn)
        $past(ar_hs, 3) |-> $rose(r.rvalid))
        else begin
            errors++;
            $error("rvalid did not rise two edges after the read address handshake");
        end

    a_r_origin: assert property (@(posedge CLK) disable iff (rstn)
        $rose(r.rvalid) |-> $past(ar_hs, 3))
        else begin
            errors++;
            $error("rvalid rose without a read address handshake two edges before");
        end

    a_b_latency: assert property (@(posedge CLK) disable iff (rstn)
        $past(wr_last, 3) |-> $rose(b.bvalid))
        else begin
            errors++;
            $error("bvalid did not rise two edges after the last write handshake");
        end

    a_b_origin: assert property (@(posedge CLK) disable iff (rstn)
        $rose(b.bvalid) |-> $past(wr_last, 3))
        else begin
            errors++;
            $error("bvalid rose without a completed write two edges before");
        end

    a_r_hold: assert property (@(posedge CLK) disable iff (rstn)
        r.rvalid && !rready |=> r.rvalid && $stable(r.rdata))
        else begin
            errors++;
            $error("read response changed while rready was low");
        end

    a_b_hold: assert property (@(posedge CLK) disable iff (rstn)
        b.bvalid && !bready |=> b.bvalid)
        else begin
            errors++;
            $error("bvalid dropped while bready was low");
        end

    a_one_read: assert property (@(posedge CLK) disable iff (rstn)
        rd_out |-> !arready)
        else begin
            errors++;
            $error("arready high while a read is outstanding");
        end

    a_one_write: assert property (@(posedge CLK) disable iff (rstn)
        wr_out |-> !awready)
        else begin
            errors++;
            $error("awready high while a write is outstanding");
        end

    // Data ahead of its address has to wait
    a_w_stall: assert property (@(posedge CLK) disable iff (rstn)
        w.wvalid && !aw.awvalid && !wr_out |-> !wready)
        else begin
            errors++;
            $error("wready high for write data with no write address");
        end

    a_rdata: assert property (@(posedge CLK) disable iff (rstn)
        r.rvalid |-> r.rdata == exp_rdata)
        else begin
            errors++;
            $error("ERROR %0t r.rdata got %h expected %h",
                   $time, $sampled(r.rdata), $sampled(exp_rdata));
        end

endmodule

bind axil_sram_top axil_sram_chk chk_i (
    .CLK     (CLK),
    .rstn    (rstn),
    .ar      (ar),
    .aw      (aw),
    .w       (w),
    .rready  (rready),
    .bready  (bready),
    .arready (arready),
    .awready (awready),
    .wready  (wready),
    .r       (r),
    .b       (b)
);

/* hw/axil_sram_top.sv */
module axil_sram_top (
    input  logic              CLK,
    input  logic              rstn,
    input  axil_pkg::ar_req_t ar,
    input  axil_pkg::aw_req_t aw,
    input  axil_pkg::w_req_t  w,
    input  logic              rready,
    input  logic              bready,
    output logic              arready,
    output logic              awready,
    output logic              wready,
    output axil_pkg::r_rsp_t  r,
    output axil_pkg::b_rsp_t  b
);

    axil_pkg::ar_req_t                 bank_ar [mem_map_pkg::NUM_BANKS];
    axil_pkg::aw_req_t                 bank_aw [mem_map_pkg::NUM_BANKS];
    axil_pkg::w_req_t                  bank_w  [mem_map_pkg::NUM_BANKS];
    axil_pkg::r_rsp_t                  bank_r  [mem_map_pkg::NUM_BANKS];
    axil_pkg::b_rsp_t                  bank_b  [mem_map_pkg::NUM_BANKS];
    logic [mem_map_pkg::NUM_BANKS-1:0] bank_arready;
    logic [mem_map_pkg::NUM_BANKS-1:0] bank_awready;
    logic [mem_map_pkg::NUM_BANKS-1:0] bank_wready;
    logic [mem_map_pkg::NUM_BANKS-1:0] bank_rready;
    logic [mem_map_pkg::NUM_BANKS-1:0] bank_bready;
    logic                              rsp_r_done;
    logic                              rsp_b_done;

    // Top-level response handshakes release the decoder
    assign rsp_r_done = r.rvalid && rready;
    assign rsp_b_done = b.bvalid && bready;

    axil_req_decode u_decode (
        .CLK          (CLK),
        .rstn         (rstn),
        .ar           (ar),
        .aw           (aw),
        .w            (w),
        .rsp_r_done   (rsp_r_done),
        .rsp_b_done   (rsp_b_done),
        .bank_arready (bank_arready),
        .bank_awready (bank_awready),
        .bank_wready  (bank_wready),
        .arready      (arready),
        .awready      (awready),
        .wready       (wready),
        .bank_ar      (bank_ar),
        .bank_aw      (bank_aw),
        .bank_w       (bank_w)
    );

    for (genvar i = 0; i < mem_map_pkg::NUM_BANKS; i++) begin : g_bank
        axil_sram_bank u_bank (
            .CLK     (CLK),
            .rstn    (rstn),
            .ar      (bank_ar[i]),
            .aw      (bank_aw[i]),
            .w       (bank_w[i]),
            .rready  (bank_rready[i]),
            .bready  (bank_bready[i]),
            .arready (bank_arready[i]),
            .awready (bank_awready[i]),
            .wready  (bank_wready[i]),
            .r       (bank_r[i]),
            .b       (bank_b[i])
        );
    end

    axil_resp_merge u_merge (
        .bank_r      (bank_r),
        .bank_b      (bank_b),
        .rready      (rready),
        .bready      (bready),
        .r           (r),
        .b           (b),
        .bank_rready (bank_rready),
        .bank_bready (bank_bready)
    );

endmodule

/* hw/axil_resp_merge.sv */
module axil_resp_merge (
    input  axil_pkg::r_rsp_t                  bank_r [mem_map_pkg::NUM_BANKS],
    input  axil_pkg::b_rsp_t                  bank_b [mem_map_pkg::NUM_BANKS],
    input  logic                              rready,
    input  logic                              bready,
    output axil_pkg::r_rsp_t                  r,
    output axil_pkg::b_rsp_t                  b,
    output logic [mem_map_pkg::NUM_BANKS-1:0] bank_rready,
    output logic [mem_map_pkg::NUM_BANKS-1:0] bank_bready
);

    axil_pkg::data_t rdata_or;
    logic            rvalid_or;
    logic            bvalid_or;

    // Only one bank can hold a read or write response at a time,
    // so a plain OR of the masked responses is enough
    always_comb begin
        rdata_or  = '0;
        rvalid_or = 1'b0;
        bvalid_or = 1'b0;
        for (int i = 0; i < mem_map_pkg::NUM_BANKS; i++) begin
            rvalid_or = rvalid_or | bank_r[i].rvalid;
            bvalid_or = bvalid_or | bank_b[i].bvalid;
            if (bank_r[i].rvalid) begin
                rdata_or = rdata_or | bank_r[i].rdata;
            end
        end
    end

    assign r.rdata  = rdata_or;
    assign r.rvalid = rvalid_or;
    assign b.bvalid = bvalid_or;

    // Idle banks ignore ready
    assign bank_rready = {mem_map_pkg::NUM_BANKS{rready}};
    assign bank_bready = {mem_map_pkg::NUM_BANKS{bready}};

endmodule

/* hw/axil_sram_bank.sv */
module axil_sram_bank (
    input  logic              CLK,
    input  logic              rstn,
    input  axil_pkg::ar_req_t ar,
    input  axil_pkg::aw_req_t aw,
    input  axil_pkg::w_req_t  w,
    input  logic              rready,
    input  logic              bready,
    output logic              arready,
    output logic              awready,
    output logic              wready,
    output axil_pkg::r_rsp_t  r,
    output axil_pkg::b_rsp_t  b
);

    axil_pkg::data_t mem [mem_map_pkg::BANK_DEPTH];

    mem_map_pkg::bank_rd_state_t rd_st;
    mem_map_pkg::bank_wr_state_t wr_st;
    mem_map_pkg::word_idx_t      rd_idx_q;
    mem_map_pkg::word_idx_t      wr_idx_q;
    axil_pkg::data_t             rdata_q;
    axil_pkg::data_t             wdata_q;
    axil_pkg::strb_t             wstrb_q;
    axil_pkg::data_t             wr_word_q;
    axil_pkg::data_t             merged;
    logic                        rvalid_q;
    logic                        bvalid_q;
    logic                        wr_merge;
    logic                        wr_commit;
    logic                        ar_hs;
    logic                        aw_hs;
    logic                        w_hs;

    assign ar_hs    = ar.arvalid && arready;
    assign aw_hs    = aw.awvalid && awready;
    assign w_hs     = w.wvalid && wready;
    assign r.rdata  = rdata_q;
    assign r.rvalid = rvalid_q;
    assign b.bvalid = bvalid_q;

    always_ff @(posedge CLK) begin
        if (rstn) begin
            rd_st    <= mem_map_pkg::RD_IDLE;
            arready  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            case (rd_st)
                mem_map_pkg::RD_IDLE: begin
                    arready <= !ar_hs;
                    if (ar_hs) begin
                        rd_st <= mem_map_pkg::RD_DATA;
                    end
                end
                mem_map_pkg::RD_DATA: begin
                    rd_st <= mem_map_pkg::RD_WAIT;
                end
                mem_map_pkg::RD_WAIT: begin
                    // rdata_q already loaded, raise valid and hold it
                    if (!rvalid_q) begin
                        rvalid_q <= 1'b1;
                    end else if (rready) begin
                        rvalid_q <= 1'b0;
                        rd_st    <= mem_map_pkg::RD_IDLE;
                    end
                end
                default: rd_st <= mem_map_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (rstn) begin
            wr_st     <= mem_map_pkg::WR_IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid_q  <= 1'b0;
            wr_merge  <= 1'b0;
            wr_commit <= 1'b0;
        end else begin
            // Merge stage then commit stage after the last handshake
            wr_merge  <= 1'b0;
            wr_commit <= wr_merge;
            case (wr_st)
                mem_map_pkg::WR_IDLE: begin
                    awready <= !aw_hs;
                    wready  <= !w_hs;
                    if (aw_hs) begin
                        // Data may arrive in the same beat
                        wr_merge <= w_hs;
                        wr_st    <= mem_map_pkg::WR_WAIT_DATA;
                    end else if (w_hs) begin
                        wr_st <= mem_map_pkg::WR_WAIT_ADDR;
                    end
                end
                mem_map_pkg::WR_WAIT_DATA: begin
                    if (w_hs) begin
                        wready   <= 1'b0;
                        wr_merge <= 1'b1;
                    end
                    if (wr_commit) begin
                        bvalid_q <= 1'b1;
                        wr_st    <= mem_map_pkg::WR_RESP;
                    end
                end
                mem_map_pkg::WR_WAIT_ADDR: begin
                    if (aw_hs) begin
                        awready  <= 1'b0;
                        wr_merge <= 1'b1;
                    end
                    if (wr_commit) begin
                        bvalid_q <= 1'b1;
                        wr_st    <= mem_map_pkg::WR_RESP;
                    end
                end
                mem_map_pkg::WR_RESP: begin
                    if (bready) begin
                        bvalid_q <= 1'b0;
                        wr_st    <= mem_map_pkg::WR_IDLE;
                    end
                end
                default: wr_st <= mem_map_pkg::WR_IDLE;
            endcase
        end
    end

    // Old word with the strobed bytes replaced
    always_comb begin
        merged = mem[wr_idx_q];
        for (int i = 0; i < axil_pkg::STRB_W; i++) begin
            if (wstrb_q[i]) begin
                merged[8*i +: 8] = wdata_q[8*i +: 8];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (ar_hs) begin
            rd_idx_q <= mem_map_pkg::word_of(ar.araddr);
        end
        if (rd_st == mem_map_pkg::RD_DATA) begin
            rdata_q <= mem[rd_idx_q];
        end
        if (aw_hs) begin
            wr_idx_q <= mem_map_pkg::word_of(aw.awaddr);
        end
        if (w_hs) begin
            wdata_q <= w.wdata;
            wstrb_q <= w.wstrb;
        end
        if (wr_merge) begin
            wr_word_q <= merged;
        end
        // Single array write, on entry to WR_RESP
        if (wr_commit) begin
            mem[wr_idx_q] <= wr_word_q;
        end
    end

endmodule

/* hw/axil_req_decode.sv */
module axil_req_decode (
    input  logic                              CLK,
    input  logic                              rstn,
    input  axil_pkg::ar_req_t                 ar,
    input  axil_pkg::aw_req_t                 aw,
    input  axil_pkg::w_req_t                  w,
    input  logic                              rsp_r_done,
    input  logic                              rsp_b_done,
    input  logic [mem_map_pkg::NUM_BANKS-1:0] bank_arready,
    input  logic [mem_map_pkg::NUM_BANKS-1:0] bank_awready,
    input  logic [mem_map_pkg::NUM_BANKS-1:0] bank_wready,
    output logic                              arready,
    output logic                              awready,
    output logic                              wready,
    output axil_pkg::ar_req_t                 bank_ar [mem_map_pkg::NUM_BANKS],
    output axil_pkg::aw_req_t                 bank_aw [mem_map_pkg::NUM_BANKS],
    output axil_pkg::w_req_t                  bank_w  [mem_map_pkg::NUM_BANKS]
);

    mem_map_pkg::bank_idx_t ar_bank;
    mem_map_pkg::bank_idx_t aw_bank;
    mem_map_pkg::bank_idx_t w_bank;
    mem_map_pkg::bank_idx_t wr_bank_q;
    logic                   rd_busy;
    logic                   wr_busy;
    logic                   w_open;

    assign ar_bank = mem_map_pkg::bank_of(ar.araddr);
    assign aw_bank = mem_map_pkg::bank_of(aw.awaddr);

    // Data follows the open write, or the address offered in the same cycle
    assign w_open = wr_busy || aw.awvalid;
    assign w_bank = wr_busy ? wr_bank_q : aw_bank;

    assign arready = !rd_busy && bank_arready[ar_bank];
    assign awready = !wr_busy && bank_awready[aw_bank];
    // Data ahead of its address stalls here
    assign wready  = w_open && bank_wready[w_bank];

    always_comb begin
        for (int i = 0; i < mem_map_pkg::NUM_BANKS; i++) begin
            bank_ar[i].araddr  = ar.araddr;
            bank_ar[i].arvalid = ar.arvalid && !rd_busy &&
                                 (ar_bank == mem_map_pkg::bank_idx_t'(i));
            bank_aw[i].awaddr  = aw.awaddr;
            bank_aw[i].awvalid = aw.awvalid && !wr_busy &&
                                 (aw_bank == mem_map_pkg::bank_idx_t'(i));
            bank_w[i].wdata    = w.wdata;
            bank_w[i].wstrb    = w.wstrb;
            bank_w[i].wvalid   = w.wvalid && w_open &&
                                 (w_bank == mem_map_pkg::bank_idx_t'(i));
        end
    end

    // One read and one write in flight at most
    always_ff @(posedge CLK) begin
        if (rstn) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            if (ar.arvalid && arready) begin
                rd_busy <= 1'b1;
            end else if (rsp_r_done) begin
                rd_busy <= 1'b0;
            end
            if (aw.awvalid && awready) begin
                wr_busy   <= 1'b1;
                wr_bank_q <= aw_bank;
            end else if (rsp_b_done) begin
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

/* hw/mem_map_pkg.sv */
package mem_map_pkg;

    localparam int BANK_IDX_W = 2;
    localparam int WORD_IDX_W = 6;
    localparam int NUM_BANKS  = 1 << BANK_IDX_W;
    localparam int BANK_DEPTH = 1 << WORD_IDX_W;

    // Bits 1:0 are the byte lane, bank field sits just above
    localparam int BANK_LSB = 2;
    localparam int WORD_LSB = BANK_LSB + BANK_IDX_W;

    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    typedef enum logic [1:0] {RD_IDLE, RD_DATA, RD_WAIT} bank_rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_WAIT_ADDR, WR_WAIT_DATA, WR_RESP} bank_wr_state_t;

    // Consecutive words land in consecutive banks
    function automatic bank_idx_t bank_of(input axil_pkg::addr_t addr);
        return addr[WORD_LSB-1:BANK_LSB];
    endfunction

    // Upper address bits alias
    function automatic word_idx_t word_of(input axil_pkg::addr_t addr);
        return addr[WORD_LSB+WORD_IDX_W-1:WORD_LSB];
    endfunction

endpackage

/* hw/axil_pkg.sv */
package axil_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // Read address channel
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
    } ar_req_t;

    // Read data channel without RRESP
    typedef struct packed {
        data_t rdata;
        logic  rvalid;
    } r_rsp_t;

    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
    } aw_req_t;

    typedef struct packed {
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
    } w_req_t;

    // Write response carries only the valid
    typedef struct packed {
        logic bvalid;
    } b_rsp_t;

endpackage
